// ==== design/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int xlen      = 32;              // Data path width
    localparam int reg_idx_w = 5;               // 32 architectural registers

    typedef logic [xlen-1:0]      word_t;       // One data word
    typedef logic [reg_idx_w-1:0] reg_idx_t;    // Register file index

    localparam word_t ebreak_insn = 32'h0010_0073;  // Only SYSTEM word that raises breakpoint

    // Major opcodes, instruction bits 6 to 0
    typedef enum logic [6:0] {
        op_bubble = 7'b000_0000,                // All-zero word inserted on a flush
        op_imm    = 7'b001_0011,                // ADDI, SLTI, SLTIU, XORI, ORI, ANDI, shifts
        op_auipc  = 7'b001_0111,
        op_reg    = 7'b011_0011,                // Register-register ALU ops
        op_lui    = 7'b011_0111,
        op_branch = 7'b110_0011,                // Six conditional branches
        op_jalr   = 7'b110_0111,
        op_jal    = 7'b110_1111,
        op_system = 7'b111_0011                 // ECALL and EBREAK
    } opcode_e;

    // Operation handed to the execute stage
    typedef enum logic [3:0] {
        alu_nop  = 4'd0,                        // Zero so a cleared register is idle
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_sll  = 4'd3,
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_xor  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_or   = 4'd9,
        alu_and  = 4'd10
    } alu_op_e;

    // Branch condition, funct3 of the BRANCH opcode
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,                          // Signed
        bge  = 3'b101,                          // Signed
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct_e;

    // Results still in flight in the three younger stages
    typedef struct packed {
        reg_idx_t rd_1c;                        // Destination of the instruction in execute
        reg_idx_t rd_2c;                        // One stage further on
        reg_idx_t rd_3c;                        // Two stages further on
        word_t    alu_out_comb;                 // Unregistered ALU result, pairs with rd_1c
        word_t    alu_output;                   // Pairs with rd_2c
        word_t    alu_out_reg_1c;               // Pairs with rd_3c
    } fwd_bus_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } alu_operands_t;

    typedef struct packed {
        logic     update_pc;                    // Load PC from the ALU result later on
        reg_idx_t rd;                           // Write-back destination
        alu_op_e  alu_op;
        logic     wb_en;                        // Register write-back enable
        logic     breakpoint;                   // EBREAK seen
        logic     bubble;                       // Empty slot, nothing retires
    } decode_ctrl_t;

endpackage

// ==== design/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
    input  rv_decode_pkg::word_t         instruction,
    input  rv_decode_pkg::word_t         pc,
    input  rv_decode_pkg::word_t         rs1_val,       // Already forwarded
    input  rv_decode_pkg::word_t         rs2_val,       // Already forwarded
    input  logic                         taken,         // Branch outcome
    output rv_decode_pkg::reg_idx_t      rs1_idx,
    output rv_decode_pkg::reg_idx_t      rs2_idx,
    output rv_decode_pkg::alu_operands_t next_operands,
    output rv_decode_pkg::decode_ctrl_t  next_ctrl
);

    import rv_decode_pkg::*;

    opcode_e opcode;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm_b;

    // Shared by OP and OP-IMM, SUB only exists in the register form
    function automatic alu_op_e alu_decode(
        input logic [2:0] funct3,
        input logic       bit30,
        input logic       reg_form
    );
        alu_op_e op;
        case (funct3)
            3'b000:  op = (reg_form && bit30) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = bit30 ? alu_sra : alu_srl;   // Arithmetic shift when bit 30 set
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instruction[6:0]);

    // RV32I immediate formats, all sign-extended from bit 31
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_u = {instruction[31:12], 12'd0};
    assign imm_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                    instruction[30:21], 1'b0};
    assign imm_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                    instruction[11:8], 1'b0};

    always_comb begin
        rs1_idx              = '0;              // Zero index never forwards
        rs2_idx              = '0;
        next_operands        = '0;
        next_ctrl            = '0;
        next_ctrl.alu_op     = alu_nop;

        case (opcode)
            op_lui: begin
                next_operands.a  = imm_u;       // b stays zero
                next_ctrl.alu_op = alu_add;
                next_ctrl.rd     = instruction[11:7];
                next_ctrl.wb_en  = 1'b1;
            end
            op_auipc: begin
                next_operands.a  = imm_u;
                next_operands.b  = pc;
                next_ctrl.alu_op = alu_add;
                next_ctrl.rd     = instruction[11:7];
                next_ctrl.wb_en  = 1'b1;
            end
            op_jal: begin
                next_operands.a     = imm_j;    // Target is pc plus offset
                next_operands.b     = pc;
                next_ctrl.alu_op    = alu_add;
                next_ctrl.rd        = instruction[11:7];
                next_ctrl.wb_en     = 1'b1;
                next_ctrl.update_pc = 1'b1;
            end
            op_jalr: begin
                rs1_idx             = instruction[19:15];
                next_operands.a     = imm_i;
                next_operands.b     = rs1_val;  // Base register
                next_ctrl.alu_op    = alu_add;
                next_ctrl.rd        = instruction[11:7];
                next_ctrl.wb_en     = 1'b1;
                next_ctrl.update_pc = 1'b1;
            end
            op_branch: begin
                rs1_idx             = instruction[19:15];
                rs2_idx             = instruction[24:20];
                next_operands.a     = pc;
                next_operands.b     = imm_b;
                next_ctrl.alu_op    = taken ? alu_add : alu_nop;   // Target only when taken
                next_ctrl.update_pc = taken;
            end
            op_imm: begin
                rs1_idx          = instruction[19:15];
                next_operands.a  = rs1_val;
                next_operands.b  = imm_i;       // Shift amount sits in the low 5 bits
                next_ctrl.alu_op = alu_decode(instruction[14:12], instruction[30], 1'b0);
                next_ctrl.rd     = instruction[11:7];
                next_ctrl.wb_en  = 1'b1;
            end
            op_reg: begin
                rs1_idx          = instruction[19:15];
                rs2_idx          = instruction[24:20];
                next_operands.a  = rs1_val;
                next_operands.b  = rs2_val;
                next_ctrl.alu_op = alu_decode(instruction[14:12], instruction[30], 1'b1);
                next_ctrl.rd     = instruction[11:7];
                next_ctrl.wb_en  = 1'b1;
            end
            op_system: begin
                next_ctrl.breakpoint = (instruction == ebreak_insn);  // ECALL stays idle
            end
            op_bubble: begin
                next_ctrl.bubble = (instruction == '0);  // Only the whole zero word
            end
            default: begin
                // FENCE and unknown opcodes leave everything inactive
            end
        endcase
    end

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_decode_pkg::reg_idx_t rs1_idx,
    input  rv_decode_pkg::reg_idx_t rs2_idx,
    input  rv_decode_pkg::word_t    rs1_data,   // Register file read ports
    input  rv_decode_pkg::word_t    rs2_data,
    input  rv_decode_pkg::fwd_bus_t fwd,
    output rv_decode_pkg::word_t    rs1_val,
    output rv_decode_pkg::word_t    rs2_val
);

    import rv_decode_pkg::*;

    // Youngest producer wins, x0 is hardwired and never bypassed
    function automatic word_t forward_pick(
        input reg_idx_t idx,
        input word_t    rf_data,
        input fwd_bus_t bus
    );
        word_t val;
        if (idx == '0) begin
            val = rf_data;
        end else if (idx == bus.rd_1c) begin
            val = bus.alu_out_comb;             // Result still inside the ALU
        end else if (idx == bus.rd_2c) begin
            val = bus.alu_output;
        end else if (idx == bus.rd_3c) begin
            val = bus.alu_out_reg_1c;           // Oldest in-flight result
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rs1_val = forward_pick(rs1_idx, rs1_data, fwd);
    assign rs2_val = forward_pick(rs2_idx, rs2_data, fwd);

    // x0 reads must bypass every stage even if a stage targets x0
    a_rs1_zero_from_rf: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1_idx == '0) |-> (rs1_val == rs1_data)
    );

    a_rs2_zero_from_rf: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs2_idx == '0) |-> (rs2_val == rs2_data)
    );

endmodule

// ==== design/branch_compare.sv ====
`timescale 1ns/1ps

module branch_compare (
    input  rv_decode_pkg::branch_funct_e funct3,
    input  rv_decode_pkg::word_t         a,     // Forwarded rs1
    input  rv_decode_pkg::word_t         b,     // Forwarded rs2
    output logic                         taken
);

    import rv_decode_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));    // BLT and BGE
    assign lt_u = (a < b);                      // BLTU and BGEU

    always_comb begin
        case (funct3)
            beq:     taken = eq;
            bne:     taken = !eq;
            blt:     taken = lt_s;
            bge:     taken = !lt_s;
            bltu:    taken = lt_u;
            bgeu:    taken = !lt_u;
            default: taken = 1'b0;              // Codes 2 and 3 are reserved
        endcase
    end

endmodule

// ==== design/decode_stage_reg.sv ====
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         halt,          // Pipeline stall
    input  rv_decode_pkg::alu_operands_t next_operands,
    input  rv_decode_pkg::decode_ctrl_t  next_ctrl,
    output rv_decode_pkg::alu_operands_t operands,
    output rv_decode_pkg::decode_ctrl_t  ctrl
);

    // Cleared ctrl means alu_nop, no write-back, no PC update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            operands <= '0;
            ctrl     <= '0;
        end else if (!halt) begin
            operands <= next_operands;
            ctrl     <= next_ctrl;
        end
    end

    // A stall freezes the whole stage for that cycle
    a_halt_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        halt |=> ($stable(operands) && $stable(ctrl))
    );

    // Decoder never asks for a jump from a breakpoint or an empty slot
    a_ctrl_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.update_pc && (ctrl.breakpoint || ctrl.bubble))
    );

endmodule

// ==== design/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         halt,
    input  rv_decode_pkg::word_t         instruction,
    input  rv_decode_pkg::word_t         pc,
    input  rv_decode_pkg::word_t         rs1_data,
    input  rv_decode_pkg::word_t         rs2_data,
    input  rv_decode_pkg::fwd_bus_t      fwd,           // From execute, memory and write-back
    output rv_decode_pkg::reg_idx_t      rs1_idx,       // To the register file, same cycle
    output rv_decode_pkg::reg_idx_t      rs2_idx,
    output rv_decode_pkg::alu_operands_t operands,      // Registered into execute
    output rv_decode_pkg::decode_ctrl_t  ctrl
);

    import rv_decode_pkg::*;

    word_t         rs1_val;
    word_t         rs2_val;
    logic          taken;
    branch_funct_e br_funct;
    alu_operands_t next_operands;
    decode_ctrl_t  next_ctrl;

    assign br_funct = branch_funct_e'(instruction[14:12]);

    control_decoder i_decoder (
        .instruction   (instruction),
        .pc            (pc),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .taken         (taken),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .next_operands (next_operands),
        .next_ctrl     (next_ctrl)
    );

    operand_forward i_forward (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (fwd),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val)
    );

    branch_compare i_compare (
        .funct3 (br_funct),                     // Ignored outside BRANCH
        .a      (rs1_val),
        .b      (rs2_val),
        .taken  (taken)
    );

    decode_stage_reg i_stage_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .halt          (halt),
        .next_operands (next_operands),
        .next_ctrl     (next_ctrl),
        .operands      (operands),
        .ctrl          (ctrl)
    );

endmodule

// ==== include/tb_decode_vectors.svh ====
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

typedef struct packed {
    word_t         instruction;
    word_t         pc;
    word_t         rs1_data;
    word_t         rs2_data;
    fwd_bus_t      fwd;
    logic          halt;                            // Stall for this cycle
    reg_idx_t      exp_rs1_idx;                     // Seen before the edge
    reg_idx_t      exp_rs2_idx;
    alu_operands_t exp_operands;                    // Seen after the edge
    decode_ctrl_t  exp_ctrl;
} decode_vector_t;

decode_vector_t vectors[$];
logic [31:0]    rng_state     = 32'hda16;
alu_operands_t  last_operands = '0;                 // What the stage register holds
decode_ctrl_t   last_ctrl     = '0;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;        // Numerical Recipes constants
endfunction

function logic [31:0] rand_word();
    rng_state = lcg_step(rng_state);
    return rng_state;
endfunction

function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1, input logic [2:0] f3,
                                input reg_idx_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};            // Low 12 bits of the offset
endfunction

function automatic word_t enc_u(input word_t imm, input reg_idx_t rd, input logic [6:0] op);
    return {imm[31:12], rd, op};
endfunction

function automatic word_t enc_j(input word_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
endfunction

function automatic word_t enc_b(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
endfunction

function automatic decode_ctrl_t make_ctrl(input logic upd, input reg_idx_t rd,
                                           input alu_op_e op, input logic wb,
                                           input logic bp, input logic bub);
    decode_ctrl_t c;
    c.update_pc  = upd;
    c.rd         = rd;
    c.alu_op     = op;
    c.wb_en      = wb;
    c.breakpoint = bp;
    c.bubble     = bub;
    return c;
endfunction

// Random data everywhere, nothing in flight, everything expected idle
function decode_vector_t base_vector(input word_t insn);
    decode_vector_t v;
    v                    = '0;
    v.instruction        = insn;
    v.pc                 = rand_word() & 32'hffff_fffc;   // Word aligned
    v.rs1_data           = rand_word();
    v.rs2_data           = rand_word();
    v.fwd.alu_out_comb   = rand_word();
    v.fwd.alu_output     = rand_word();
    v.fwd.alu_out_reg_1c = rand_word();
    v.exp_ctrl           = make_ctrl(1'b0, 5'd0, alu_nop, 1'b0, 1'b0, 1'b0);
    return v;
endfunction

// A halted vector expects the stage to keep the last accepted result
function void push_vector(input decode_vector_t v);
    decode_vector_t w;
    w = v;
    if (w.halt) begin
        w.exp_operands = last_operands;
        w.exp_ctrl     = last_ctrl;
    end else begin
        last_operands = w.exp_operands;
        last_ctrl     = w.exp_ctrl;
    end
    vectors.push_back(w);
endfunction

function void add_branch(input logic [2:0] f3, input logic equal, input logic tk);
    decode_vector_t v;
    v             = base_vector(enc_b(32'hffff_fff0, 5'd12, 5'd11, f3));
    v.rs1_data    = rand_word() | 32'h8000_0000;        // Negative signed, large unsigned
    v.rs2_data    = equal ? v.rs1_data : (rand_word() & 32'h7fff_ffff);
    v.exp_rs1_idx = 5'd11;
    v.exp_rs2_idx = 5'd12;
    v.exp_operands = {v.pc, 32'hffff_fff0};             // Target is pc minus 16
    v.exp_ctrl    = make_ctrl(tk, 5'd0, tk ? alu_add : alu_nop, 1'b0, 1'b0, 1'b0);
    push_vector(v);
endfunction

function void fill_vectors();
    decode_vector_t v;
    alu_op_e        exp_reg [16];
    alu_op_e        exp_imm [16];
    word_t          imm;
    exp_reg = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and,
                alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_sra, alu_or, alu_and};
    exp_imm = '{alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_or, alu_and,
                alu_add, alu_sll, alu_slt, alu_sltu, alu_xor, alu_sra, alu_or, alu_and};
    v = base_vector(enc_u(32'hfedc_b000, 5'd3, op_lui));           // LUI, top bit set
    v.exp_operands = {32'hfedc_b000, 32'd0};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd3, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_u(32'h1234_5000, 5'd4, op_auipc));
    v.exp_operands = {32'h1234_5000, v.pc};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd4, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_j(32'hffff_f800, 5'd1));                   // JAL back 2 KiB
    v.exp_operands = {32'hffff_f800, v.pc};
    v.exp_ctrl     = make_ctrl(1'b1, 5'd1, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_j(32'h0001_2344, 5'd2));                   // JAL forward
    v.exp_operands = {32'h0001_2344, v.pc};
    v.exp_ctrl     = make_ctrl(1'b1, 5'd2, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_i(32'hffff_fff8, 5'd7, 3'd0, 5'd1, op_jalr));
    v.exp_rs1_idx  = 5'd7;
    v.exp_operands = {32'hffff_fff8, v.rs1_data};
    v.exp_ctrl     = make_ctrl(1'b1, 5'd1, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    for (int k = 0; k < 16; k++) begin                              // Index is {bit30, funct3}
        v = base_vector(enc_r({1'b0, k[3], 5'd0}, 5'd6, 5'd5, k[2:0], 5'd9));
        v.exp_rs1_idx  = 5'd5;
        v.exp_rs2_idx  = 5'd6;
        v.exp_operands = {v.rs1_data, v.rs2_data};
        v.exp_ctrl     = make_ctrl(1'b0, 5'd9, exp_reg[k], 1'b1, 1'b0, 1'b0);
        push_vector(v);
    end
    for (int k = 0; k < 16; k++) begin
        imm = k[3] ? 32'h0000_0403 : 32'h0000_0003;                 // Imm bit 10 is insn bit 30
        v = base_vector(enc_i(imm, 5'd5, k[2:0], 5'd10, op_imm));
        v.exp_rs1_idx  = 5'd5;
        v.exp_operands = {v.rs1_data, imm};
        v.exp_ctrl     = make_ctrl(1'b0, 5'd10, exp_imm[k], 1'b1, 1'b0, 1'b0);
        push_vector(v);
    end
    add_branch(3'b000, 1'b0, 1'b0);                                 // BEQ, differ
    add_branch(3'b001, 1'b0, 1'b1);                                 // BNE, differ
    add_branch(3'b100, 1'b0, 1'b1);                                 // BLT, negative < positive
    add_branch(3'b101, 1'b0, 1'b0);                                 // BGE
    add_branch(3'b110, 1'b0, 1'b0);                                 // BLTU, large not below small
    add_branch(3'b111, 1'b0, 1'b1);                                 // BGEU
    add_branch(3'b000, 1'b1, 1'b1);                                 // BEQ, equal
    add_branch(3'b001, 1'b1, 1'b0);                                 // BNE, equal
    v = base_vector(enc_r(7'd0, 5'd15, 5'd14, 3'd0, 5'd13));        // Youngest stage wins
    v.fwd.rd_1c = 5'd14;
    v.fwd.rd_2c = 5'd14;
    v.fwd.rd_3c = 5'd15;
    v.exp_rs1_idx  = 5'd14;
    v.exp_rs2_idx  = 5'd15;
    v.exp_operands = {v.fwd.alu_out_comb, v.fwd.alu_out_reg_1c};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd13, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_r(7'd0, 5'd15, 5'd14, 3'd0, 5'd13));
    v.fwd.rd_1c = 5'd20;
    v.fwd.rd_2c = 5'd14;
    v.fwd.rd_3c = 5'd14;
    v.exp_rs1_idx  = 5'd14;
    v.exp_rs2_idx  = 5'd15;
    v.exp_operands = {v.fwd.alu_output, v.rs2_data};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd13, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_r(7'd0, 5'd15, 5'd0, 3'd0, 5'd13));         // x0 with rd_1c also x0
    v.fwd.rd_1c = 5'd0;
    v.fwd.rd_2c = 5'd1;
    v.fwd.rd_3c = 5'd15;
    v.exp_rs2_idx  = 5'd15;
    v.exp_operands = {v.rs1_data, v.fwd.alu_out_reg_1c};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd13, alu_add, 1'b1, 1'b0, 1'b0);
    push_vector(v);
    v = base_vector(enc_i(32'd100, 5'd5, 3'd0, 5'd2, op_imm));      // Held for three cycles
    v.exp_rs1_idx  = 5'd5;
    v.exp_operands = {v.rs1_data, 32'd100};
    v.exp_ctrl     = make_ctrl(1'b0, 5'd2, alu_add, 1'b1, 1'b0, 1'b0);
    v.halt = 1'b1;
    repeat (3) push_vector(v);
    v.halt = 1'b0;
    push_vector(v);
    v = base_vector(32'h0010_0073);                                 // EBREAK
    v.exp_ctrl = make_ctrl(1'b0, 5'd0, alu_nop, 1'b0, 1'b1, 1'b0);
    push_vector(v);
    v = base_vector(32'h0000_0000);                                 // Bubble word
    v.exp_ctrl = make_ctrl(1'b0, 5'd0, alu_nop, 1'b0, 1'b0, 1'b1);
    push_vector(v);
endfunction

`endif

// ==== tb/tb_instruction_decode.sv ====
`timescale 1ns/1ps

module tb_instruction_decode;

    import rv_decode_pkg::*;

    `include "tb_decode_vectors.svh"

    localparam int reset_cycles = 10;

    logic          clk;
    logic          rst_n;
    logic          halt;
    word_t         instruction;
    word_t         pc;
    word_t         rs1_data;
    word_t         rs2_data;
    fwd_bus_t      fwd;
    reg_idx_t      rs1_idx;
    reg_idx_t      rs2_idx;
    alu_operands_t operands;
    decode_ctrl_t  ctrl;

    int errors      = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;                         // Replaced once the table is built

    instruction_decode i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .halt        (halt),
        .instruction (instruction),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .fwd         (fwd),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .operands    (operands),
        .ctrl        (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    task automatic drive_vector(input decode_vector_t v);
        instruction = v.instruction;
        pc          = v.pc;
        rs1_data    = v.rs1_data;
        rs2_data    = v.rs2_data;
        fwd         = v.fwd;
        halt        = v.halt;
    endtask

    // Register file indices are combinational
    task automatic check_indices(input decode_vector_t v, input int n);
        assert (rs1_idx === v.exp_rs1_idx) else begin
            errors++;
            $display("Error at %0t: vector %0d rs1_idx got %0d expected %0d",
                     $time, n, rs1_idx, v.exp_rs1_idx);
        end
        assert (rs2_idx === v.exp_rs2_idx) else begin
            errors++;
            $display("Error at %0t: vector %0d rs2_idx got %0d expected %0d",
                     $time, n, rs2_idx, v.exp_rs2_idx);
        end
    endtask

    task automatic check_stage(input alu_operands_t exp_ops, input decode_ctrl_t exp_ctrl,
                               input int n);
        assert (operands.a === exp_ops.a) else begin
            errors++;
            $display("Error at %0t: vector %0d operand a got %h expected %h",
                     $time, n, operands.a, exp_ops.a);
        end
        assert (operands.b === exp_ops.b) else begin
            errors++;
            $display("Error at %0t: vector %0d operand b got %h expected %h",
                     $time, n, operands.b, exp_ops.b);
        end
        assert (ctrl === exp_ctrl) else begin
            errors++;
            $display("Error at %0t: vector %0d ctrl got %h expected %h",
                     $time, n, ctrl, exp_ctrl);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        halt        = 1'b0;
        instruction = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        fwd         = '0;
        fill_vectors();
        cycle_limit = 2 * vectors.size() + reset_cycles + 20;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_stage('0, '0, -1);                    // Idle right out of reset
        for (int n = 0; n < vectors.size(); n++) begin
            drive_vector(vectors[n]);               // 2 ns after the edge
            #8;
            check_indices(vectors[n], n);
            @(posedge clk);
            #1;
            check_stage(vectors[n].exp_operands, vectors[n].exp_ctrl, n);
            #1;
        end
        $display("Errors: %0d in %0d vectors", errors, vectors.size());
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog in case the stimulus loop stalls
    initial begin
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("test failed");
        $finish;
    end

endmodule

// ==== instruction_decode.f ====
+incdir+include
design/rv_decode_pkg.sv
design/control_decoder.sv
design/operand_forward.sv
design/branch_compare.sv
design/decode_stage_reg.sv
design/instruction_decode.sv
tb/tb_instruction_decode.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_instruction_decode
FILELIST = instruction_decode.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
